/* design/eth_pkg.sv */
// Ethernet loopback shared definitions
package eth_pkg;

    // Widths with a meaning of their own
    typedef logic [7:0]  eth_byte_t;
    typedef logic [15:0] frame_count_t;
    typedef logic [31:0] crc32_t;

    // One byte of the internal frame stream
    typedef struct packed {
        eth_byte_t data;
        logic      last;
        // Only meaningful together with last
        logic      bad;
    } stream_beat_t;

    // GMII framing
    localparam eth_byte_t PREAMBLE_BYTE   = 8'h55;
    localparam eth_byte_t SFD_BYTE        = 8'hD5;
    localparam int        PREAMBLE_LEN    = 7;
    localparam int        MIN_PAYLOAD_LEN = 60;
    localparam int        FCS_LEN         = 4;
    localparam int        IFG_LEN         = 12;

    // Frame buffer
    localparam int FIFO_DEPTH = 2048;
    typedef logic [$clog2(FIFO_DEPTH)-1:0] fifo_addr_t;

    // IEEE 802.3 CRC-32, reflected form
    localparam crc32_t CRC_POLY    = 32'hEDB88320;
    localparam crc32_t CRC_INIT    = 32'hFFFFFFFF;
    // Register value after a frame plus its own FCS has been folded in
    localparam crc32_t CRC_RESIDUE = 32'hDEBB20E3;

    // Fold one byte into the running CRC, LSB first as on the wire
    function automatic crc32_t crc32_next(input crc32_t crc, input eth_byte_t data);
        crc32_t c;
        c = crc ^ crc32_t'(data);
        for (int i = 0; i < 8; i++) begin
            if (c[0]) begin
                c = (c >> 1) ^ CRC_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

endpackage

/* design/gmii_rx_stage.sv */
// GMII receive stage
`timescale 1ns/1ps

module gmii_rx_stage (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire eth_pkg::eth_byte_t    gmii_rxd,
    input  wire logic                  gmii_rx_dv,
    input  wire logic                  gmii_rx_er,
    output logic                       rx_valid,
    output eth_pkg::stream_beat_t      rx_beat,
    output eth_pkg::frame_count_t      rx_good_count,
    output eth_pkg::frame_count_t      rx_bad_count
);

typedef enum logic [1:0] {
    STATE_IDLE,
    STATE_PREAMBLE,
    STATE_DATA
} state_t;

state_t state;

// rx_dv one cycle back, so only a fresh assertion starts a frame
logic dv_q;

eth_pkg::crc32_t crc;
logic            err_seen;

// Last four bytes may turn out to be the FCS, so they are held back
eth_pkg::eth_byte_t fcs_dly [4];
// One more byte so that last can ride on the final data byte
eth_pkg::eth_byte_t held_byte;
// Bytes held so far, saturates at 5
logic [2:0]         fill;

logic emit_mid;
logic emit_end;
logic frame_bad;

assign emit_mid  = (state == STATE_DATA) && gmii_rx_dv && (fill == 3'd5);
assign emit_end  = (state == STATE_DATA) && !gmii_rx_dv && (fill == 3'd5);
assign frame_bad = err_seen || (crc != eth_pkg::CRC_RESIDUE);

// Delay line and output byte
always_ff @(posedge clk) begin
    if ((state == STATE_DATA) && gmii_rx_dv) begin
        fcs_dly[0] <= gmii_rxd;
        fcs_dly[1] <= fcs_dly[0];
        fcs_dly[2] <= fcs_dly[1];
        fcs_dly[3] <= fcs_dly[2];
        held_byte  <= fcs_dly[3];
    end
    if (emit_mid || emit_end) begin
        rx_beat.data <= held_byte;
        rx_beat.last <= emit_end;
        rx_beat.bad  <= emit_end && frame_bad;
    end
end

always_ff @(posedge clk) begin
    if (reset) begin
        state         <= STATE_IDLE;
        dv_q          <= 1'b0;
        fill          <= '0;
        err_seen      <= 1'b0;
        crc           <= eth_pkg::CRC_INIT;
        rx_valid      <= 1'b0;
        rx_good_count <= '0;
        rx_bad_count  <= '0;
    end else begin
        dv_q     <= gmii_rx_dv;
        rx_valid <= emit_mid || emit_end;

        case (state)
            STATE_IDLE: begin
                if (gmii_rx_dv && !dv_q && (gmii_rxd == eth_pkg::PREAMBLE_BYTE)) begin
                    state <= STATE_PREAMBLE;
                end
            end
            STATE_PREAMBLE: begin
                fill     <= '0;
                err_seen <= 1'b0;
                crc      <= eth_pkg::CRC_INIT;
                if (!gmii_rx_dv) begin
                    state <= STATE_IDLE;
                end else if (gmii_rxd == eth_pkg::SFD_BYTE) begin
                    state <= STATE_DATA;
                end else if (gmii_rxd != eth_pkg::PREAMBLE_BYTE) begin
                    // Junk before the SFD, skip the rest of this frame
                    state <= STATE_IDLE;
                end
            end
            STATE_DATA: begin
                if (gmii_rx_dv) begin
                    crc <= eth_pkg::crc32_next(crc, gmii_rxd);
                    if (gmii_rx_er) begin
                        err_seen <= 1'b1;
                    end
                    if (fill != 3'd5) begin
                        fill <= fill + 3'd1;
                    end
                end else begin
                    state <= STATE_IDLE;
                    // Frames without a data byte vanish here without a count
                    if (emit_end && frame_bad) begin
                        rx_bad_count <= rx_bad_count + 1'b1;
                    end else if (emit_end) begin
                        rx_good_count <= rx_good_count + 1'b1;
                    end
                end
            end
            default: begin
                state <= STATE_IDLE;
            end
        endcase
    end
end

// A frame leaves as one unbroken run of beats, closed by last
a_beats_contiguous: assert property (
    @(posedge clk) disable iff (reset) rx_valid && !rx_beat.last |=> rx_valid
);

endmodule

/* design/frame_fifo.sv */
// Store-and-forward frame FIFO
`timescale 1ns/1ps

module frame_fifo (
    input  wire logic                    clk,
    input  wire logic                    reset,

    // Push side from the receiver, cannot stall
    input  wire logic                    rx_valid,
    input  wire eth_pkg::stream_beat_t   rx_beat,

    // Pull side towards the transmitter
    output logic                         tx_valid,
    input  wire logic                    tx_ready,
    output eth_pkg::stream_beat_t        tx_beat,

    output eth_pkg::frame_count_t        fifo_drop_count
);

eth_pkg::stream_beat_t mem [eth_pkg::FIFO_DEPTH];

// Write pointer runs ahead through the frame being received
eth_pkg::fifo_addr_t wr_ptr;
// End of the last complete good frame
eth_pkg::fifo_addr_t commit_ptr;
eth_pkg::fifo_addr_t rd_ptr;

// Bytes stored including the open frame, and committed bytes only
eth_pkg::fifo_addr_t used_all;
eth_pkg::fifo_addr_t used_commit;

logic full;
// Set while the tail of an overflowed frame is thrown away
logic dropping;
logic wr_accept;
logic rd_fire;

assign used_all    = wr_ptr - rd_ptr;
assign used_commit = commit_ptr - rd_ptr;

// One slot is always left free, so full and empty look different
assign full = (used_all == eth_pkg::fifo_addr_t'(eth_pkg::FIFO_DEPTH - 1));

assign wr_accept = rx_valid && !dropping && !full;

// Only whole good frames are ever visible to the transmitter
assign tx_valid = (used_commit != '0);
assign rd_fire  = tx_valid && tx_ready;
assign tx_beat  = mem[rd_ptr];

// Buffer RAM
always_ff @(posedge clk) begin
    if (wr_accept) begin
        mem[wr_ptr] <= rx_beat;
    end
end

always_ff @(posedge clk) begin
    if (reset) begin
        wr_ptr          <= '0;
        commit_ptr      <= '0;
        rd_ptr          <= '0;
        dropping        <= 1'b0;
        fifo_drop_count <= '0;
    end else begin
        if (rd_fire) begin
            rd_ptr <= rd_ptr + 1'b1;
        end

        if (rx_valid) begin
            if (dropping) begin
                // Wait for the end of the frame that did not fit
                if (rx_beat.last) begin
                    dropping <= 1'b0;
                end
            end else if (full) begin
                // Out of room, roll back and discard the remainder
                wr_ptr          <= commit_ptr;
                fifo_drop_count <= fifo_drop_count + 1'b1;
                dropping        <= !rx_beat.last;
            end else if (rx_beat.last && rx_beat.bad) begin
                wr_ptr          <= commit_ptr;
                fifo_drop_count <= fifo_drop_count + 1'b1;
            end else if (rx_beat.last) begin
                // Good end of frame, publish it
                wr_ptr     <= wr_ptr + 1'b1;
                commit_ptr <= wr_ptr + 1'b1;
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end
end

// Reads stay behind the commit point, which stays behind the writer
a_read_behind_commit: assert property (
    @(posedge clk) disable iff (reset) used_commit <= used_all
);

endmodule

/* design/gmii_tx_stage.sv */
// GMII transmit stage
`timescale 1ns/1ps

module gmii_tx_stage (
    input  wire logic                    clk,
    input  wire logic                    reset,

    // Frame stream from the FIFO
    input  wire logic                    tx_valid,
    output logic                         tx_ready,
    input  wire eth_pkg::stream_beat_t   tx_beat,

    // GMII transmit
    output eth_pkg::eth_byte_t           gmii_txd,
    output logic                         gmii_tx_en,
    output logic                         gmii_tx_er
);

typedef enum logic [2:0] {
    STATE_IDLE,
    STATE_PREAMBLE,
    STATE_DATA,
    STATE_PAD,
    STATE_FCS,
    STATE_IFG
} state_t;

state_t state;

// Position within the current section of the frame
eth_pkg::fifo_addr_t byte_cnt;
eth_pkg::crc32_t     crc;

// tx_en over the last IFG_LEN cycles, for the gap check
logic [eth_pkg::IFG_LEN-1:0] en_hist;

// Beats are taken only while data goes out
assign tx_ready = (state == STATE_DATA);

// No error propagation towards the PHY
assign gmii_tx_er = 1'b0;

always_ff @(posedge clk) begin
    if (reset) begin
        state      <= STATE_IDLE;
        byte_cnt   <= '0;
        crc        <= eth_pkg::CRC_INIT;
        gmii_txd   <= '0;
        gmii_tx_en <= 1'b0;
    end else begin
        case (state)
            STATE_IDLE: begin
                gmii_txd   <= '0;
                gmii_tx_en <= 1'b0;
                if (tx_valid) begin
                    // A whole frame waits in the FIFO, start the preamble
                    gmii_txd   <= eth_pkg::PREAMBLE_BYTE;
                    gmii_tx_en <= 1'b1;
                    byte_cnt   <= eth_pkg::fifo_addr_t'(1);
                    state      <= STATE_PREAMBLE;
                end
            end
            STATE_PREAMBLE: begin
                crc <= eth_pkg::CRC_INIT;
                if (byte_cnt == eth_pkg::fifo_addr_t'(eth_pkg::PREAMBLE_LEN)) begin
                    gmii_txd <= eth_pkg::SFD_BYTE;
                    byte_cnt <= '0;
                    state    <= STATE_DATA;
                end else begin
                    gmii_txd <= eth_pkg::PREAMBLE_BYTE;
                    byte_cnt <= byte_cnt + 1'b1;
                end
            end
            STATE_DATA: begin
                // Frame is stored in full, so valid holds through this state
                if (tx_valid) begin
                    gmii_txd <= tx_beat.data;
                    crc      <= eth_pkg::crc32_next(crc, tx_beat.data);
                    byte_cnt <= byte_cnt + 1'b1;
                    if (tx_beat.last) begin
                        if (byte_cnt < eth_pkg::fifo_addr_t'(eth_pkg::MIN_PAYLOAD_LEN - 1)) begin
                            state <= STATE_PAD;
                        end else begin
                            byte_cnt <= '0;
                            state    <= STATE_FCS;
                        end
                    end
                end
            end
            STATE_PAD: begin
                gmii_txd <= '0;
                crc      <= eth_pkg::crc32_next(crc, eth_pkg::eth_byte_t'(0));
                if (byte_cnt == eth_pkg::fifo_addr_t'(eth_pkg::MIN_PAYLOAD_LEN - 1)) begin
                    byte_cnt <= '0;
                    state    <= STATE_FCS;
                end else begin
                    byte_cnt <= byte_cnt + 1'b1;
                end
            end
            STATE_FCS: begin
                // Complemented CRC, low byte first
                gmii_txd <= ~crc[8*byte_cnt[1:0] +: 8];
                if (byte_cnt == eth_pkg::fifo_addr_t'(eth_pkg::FCS_LEN - 1)) begin
                    byte_cnt <= '0;
                    state    <= STATE_IFG;
                end else begin
                    byte_cnt <= byte_cnt + 1'b1;
                end
            end
            STATE_IFG: begin
                gmii_txd   <= '0;
                gmii_tx_en <= 1'b0;
                if (byte_cnt == eth_pkg::fifo_addr_t'(eth_pkg::IFG_LEN - 1)) begin
                    byte_cnt <= '0;
                    state    <= STATE_IDLE;
                end else begin
                    byte_cnt <= byte_cnt + 1'b1;
                end
            end
            default: begin
                state <= STATE_IDLE;
            end
        endcase
    end
end

always_ff @(posedge clk) begin
    if (reset) begin
        en_hist <= '0;
    end else begin
        en_hist <= {en_hist[eth_pkg::IFG_LEN-2:0], gmii_tx_en};
    end
end

// Each new frame follows at least IFG_LEN idle cycles
a_ifg_kept: assert property (
    @(posedge clk) disable iff (reset) $rose(gmii_tx_en) |-> (en_hist == '0)
);

endmodule

/* design/fpga_core.sv */
// Ethernet loopback top level
`timescale 1ns/1ps

module fpga_core (
    // 125 MHz, synchronous reset
    input  wire logic                  clk,
    input  wire logic                  reset,

    // GPIO
    input  wire logic [7:0]            sw,
    output logic [7:0]                 led,

    // GMII receive
    input  wire eth_pkg::eth_byte_t    gmii_rxd,
    input  wire logic                  gmii_rx_dv,
    input  wire logic                  gmii_rx_er,

    // GMII transmit
    output eth_pkg::eth_byte_t         gmii_txd,
    output logic                       gmii_tx_en,
    output logic                       gmii_tx_er,

    // Frame statistics
    output eth_pkg::frame_count_t      rx_good_count,
    output eth_pkg::frame_count_t      rx_bad_count,
    output eth_pkg::frame_count_t      fifo_drop_count
);

// Receiver to FIFO, push only
logic                  rx_valid;
eth_pkg::stream_beat_t rx_beat;

// FIFO to transmitter
logic                  tx_valid;
logic                  tx_ready;
eth_pkg::stream_beat_t tx_beat;

assign led = sw;

gmii_rx_stage rx_stage_inst (
    .clk(clk),
    .reset(reset),
    .gmii_rxd(gmii_rxd),
    .gmii_rx_dv(gmii_rx_dv),
    .gmii_rx_er(gmii_rx_er),
    .rx_valid(rx_valid),
    .rx_beat(rx_beat),
    .rx_good_count(rx_good_count),
    .rx_bad_count(rx_bad_count)
);

// Several received frames may queue here while one goes out
frame_fifo fifo_inst (
    .clk(clk),
    .reset(reset),
    .rx_valid(rx_valid),
    .rx_beat(rx_beat),
    .tx_valid(tx_valid),
    .tx_ready(tx_ready),
    .tx_beat(tx_beat),
    .fifo_drop_count(fifo_drop_count)
);

gmii_tx_stage tx_stage_inst (
    .clk(clk),
    .reset(reset),
    .tx_valid(tx_valid),
    .tx_ready(tx_ready),
    .tx_beat(tx_beat),
    .gmii_txd(gmii_txd),
    .gmii_tx_en(gmii_tx_en),
    .gmii_tx_er(gmii_tx_er)
);

endmodule

/* verification/fpga_core_tb.sv */
// Ethernet loopback testbench
`timescale 1ns/1ps

module fpga_core_tb;

logic                  clk;
logic                  reset;
logic [7:0]            sw;
logic [7:0]            led;
eth_pkg::eth_byte_t    gmii_rxd;
logic                  gmii_rx_dv;
logic                  gmii_rx_er;
eth_pkg::eth_byte_t    gmii_txd;
logic                  gmii_tx_en;
logic                  gmii_tx_er;
eth_pkg::frame_count_t rx_good_count;
eth_pkg::frame_count_t rx_bad_count;
eth_pkg::frame_count_t fifo_drop_count;

// Frames as read from the data file
string              file_name [$];
string              file_kind [$];
int                 file_len [$];
int                 file_base [$];
eth_pkg::crc32_t    file_fcs [$];
eth_pkg::eth_byte_t file_bytes [$];

// Expected transmitted frames, data already padded
string              exp_name [$];
int                 exp_len [$];
bit                 exp_drop_ok [$];
eth_pkg::crc32_t    exp_fcs [$];
eth_pkg::eth_byte_t exp_data [$];
int                 exp_idx;
int                 exp_base;

int n_good;
int n_bad;
int limit_cycles;
int tx_frames;

// Monitor state
eth_pkg::eth_byte_t cur [$];
bit                 in_frame;
bit                 seen_frame;
int                 idle_run;

fpga_core u_dut (
    .clk(clk),
    .reset(reset),
    .sw(sw),
    .led(led),
    .gmii_rxd(gmii_rxd),
    .gmii_rx_dv(gmii_rx_dv),
    .gmii_rx_er(gmii_rx_er),
    .gmii_txd(gmii_txd),
    .gmii_tx_en(gmii_tx_en),
    .gmii_tx_er(gmii_tx_er),
    .rx_good_count(rx_good_count),
    .rx_bad_count(rx_bad_count),
    .fifo_drop_count(fifo_drop_count)
);

initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
end

task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "Stopped at first error");
endtask

task automatic check_byte(input string name, input eth_pkg::eth_byte_t exp,
                          input eth_pkg::eth_byte_t act);
    if (exp !== act) begin
        fail_run($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
    end
endtask

task automatic check_count(input string name, input eth_pkg::frame_count_t exp,
                           input eth_pkg::frame_count_t act);
    if (exp !== act) begin
        fail_run($sformatf("Mismatch %s: expected %0d, actual %0d", name, exp, act));
    end
endtask

task automatic check_crc(input string name, input eth_pkg::crc32_t exp,
                         input eth_pkg::crc32_t act);
    if (exp !== act) begin
        fail_run($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
    end
endtask

task automatic load_frames();
    int fd;
    int code;
    int len;
    int pad_len;
    string tok;
    string kind;
    string rest;
    eth_pkg::eth_byte_t b;
    eth_pkg::crc32_t fcs;
    eth_pkg::crc32_t crc;
    fd = $fopen("verification/frame_input.txt", "r");
    if (fd == 0) begin
        fail_run("Could not open verification/frame_input.txt");
    end
    limit_cycles = 1000;
    while (!$feof(fd)) begin
        code = $fscanf(fd, "%s", tok);
        if (code != 1) begin
            break;
        end
        if (tok[0] == 8'h23) begin
            code = $fgets(rest, fd);
            continue;
        end
        code = $fscanf(fd, "%s %d", kind, len);
        file_name.push_back(tok);
        file_kind.push_back(kind);
        file_len.push_back(len);
        file_base.push_back(file_bytes.size());
        crc = eth_pkg::CRC_INIT;
        if (kind == "overflow") begin
            // One seed byte, payload counts up from it
            code = $fscanf(fd, "%h", b);
            for (int i = 0; i < len; i++) begin
                file_bytes.push_back(b + eth_pkg::eth_byte_t'(i));
            end
        end else begin
            for (int i = 0; i < len; i++) begin
                code = $fscanf(fd, "%h", b);
                file_bytes.push_back(b);
            end
        end
        for (int i = 0; i < len; i++) begin
            crc = eth_pkg::crc32_next(crc, file_bytes[file_base[$] + i]);
        end
        code = $fscanf(fd, "%h", fcs);
        if (fcs == '0) begin
            fcs = ~crc;
        end else if (kind != "badfcs") begin
            // Listed FCS must agree with the reference CRC
            check_crc({tok, "_file_fcs"}, ~crc, fcs);
        end
        file_fcs.push_back(fcs);
        limit_cycles += (len + 40) * 3;
        if (kind == "badfcs" || kind == "rxerr") begin
            n_bad++;
        end else begin
            n_good++;
            pad_len = (len < eth_pkg::MIN_PAYLOAD_LEN) ? eth_pkg::MIN_PAYLOAD_LEN : len;
            crc = eth_pkg::CRC_INIT;
            for (int i = 0; i < pad_len; i++) begin
                b = (i < len) ? file_bytes[file_base[$] + i] : 8'h00;
                exp_data.push_back(b);
                crc = eth_pkg::crc32_next(crc, b);
            end
            exp_name.push_back(tok);
            exp_len.push_back(pad_len);
            exp_drop_ok.push_back(kind == "overflow");
            exp_fcs.push_back(~crc);
        end
    end
    $fclose(fd);
endtask

task automatic run_watchdog();
    repeat (limit_cycles) @(posedge clk);
    $display("Run timed out before all frames came back");
    $display("Test failed");
    $fatal(1, "Watchdog expired");
endtask

task automatic send_frame(input int f);
    eth_pkg::eth_byte_t wire_bytes [$];
    int gap;
    for (int i = 0; i < eth_pkg::PREAMBLE_LEN; i++) begin
        wire_bytes.push_back(eth_pkg::PREAMBLE_BYTE);
    end
    wire_bytes.push_back(eth_pkg::SFD_BYTE);
    for (int i = 0; i < file_len[f]; i++) begin
        wire_bytes.push_back(file_bytes[file_base[f] + i]);
    end
    for (int i = 0; i < 4; i++) begin
        wire_bytes.push_back(file_fcs[f][8*i +: 8]);
    end
    for (int i = 0; i < wire_bytes.size(); i++) begin
        @(posedge clk);
        gmii_rxd   <= wire_bytes[i];
        gmii_rx_dv <= 1'b1;
        // Error on the second payload byte
        gmii_rx_er <= (file_kind[f] == "rxerr") && (i == 9);
    end
    @(posedge clk);
    gmii_rxd   <= '0;
    gmii_rx_dv <= 1'b0;
    gmii_rx_er <= 1'b0;
    gap = eth_pkg::IFG_LEN;
    if (file_kind[f] != "overflow") begin
        gap += $urandom % 8;
    end
    repeat (gap - 1) @(posedge clk);
endtask

task automatic compare_frame();
    int n;
    string name;
    eth_pkg::crc32_t act_fcs;
    n = cur.size() - 12;
    while (exp_idx < exp_len.size() && exp_drop_ok[exp_idx] && exp_len[exp_idx] != n) begin
        exp_base += exp_len[exp_idx];
        exp_idx++;
    end
    if (exp_idx >= exp_len.size() || n < 0) begin
        fail_run("A frame came out of gmii_txd that was never expected");
    end else begin
        name = exp_name[exp_idx];
        for (int i = 0; i < eth_pkg::PREAMBLE_LEN; i++) begin
            check_byte({name, "_preamble"}, eth_pkg::PREAMBLE_BYTE, cur[i]);
        end
        check_byte({name, "_sfd"}, eth_pkg::SFD_BYTE, cur[7]);
        check_count({name, "_length"}, exp_len[exp_idx], n);
        for (int i = 0; i < n; i++) begin
            check_byte({name, "_data"}, exp_data[exp_base + i], cur[8 + i]);
        end
        act_fcs = {cur[8 + n + 3], cur[8 + n + 2], cur[8 + n + 1], cur[8 + n]};
        check_crc({name, "_fcs"}, exp_fcs[exp_idx], act_fcs);
        exp_base += exp_len[exp_idx];
        exp_idx++;
    end
endtask

// Collects transmitted frames and watches the gap and tx_er
always @(posedge clk) begin
    if (reset) begin
        in_frame   = 1'b0;
        seen_frame = 1'b0;
        idle_run   = 0;
        cur.delete();
    end else begin
        if (gmii_tx_er !== 1'b0) begin
            fail_run("gmii_tx_er went high");
        end
        if (gmii_tx_en) begin
            if (!in_frame && seen_frame && idle_run < eth_pkg::IFG_LEN) begin
                fail_run($sformatf("Inter-frame gap of only %0d cycles", idle_run));
            end
            in_frame = 1'b1;
            idle_run = 0;
            cur.push_back(gmii_txd);
        end else begin
            if (in_frame) begin
                compare_frame();
                tx_frames++;
                seen_frame = 1'b1;
                cur.delete();
            end
            in_frame = 1'b0;
            idle_run++;
        end
    end
end

initial begin
    reset      = 1'b1;
    sw         = '0;
    gmii_rxd   = '0;
    gmii_rx_dv = 1'b0;
    gmii_rx_er = 1'b0;
    void'($urandom(67));
    load_frames();
    fork
        run_watchdog();
    join_none
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_count("reset_good", 0, rx_good_count);
    check_count("reset_bad", 0, rx_bad_count);
    check_count("reset_drop", 0, fifo_drop_count);

    repeat (4) begin
        @(posedge clk);
        sw <= 8'($urandom);
        @(negedge clk);
        check_byte("led_follows_sw", sw, led);
    end

    for (int f = 0; f < file_name.size(); f++) begin
        send_frame(f);
    end

    // Every expected frame is either compared or passed over as an overflow loss
    do begin
        @(negedge clk);
    end while (exp_idx < exp_len.size() || in_frame || gmii_tx_en);

    check_count("rx_good_count", n_good, rx_good_count);
    check_count("rx_bad_count", n_bad, rx_bad_count);
    check_count("fifo_drop_count", n_bad + n_good - tx_frames, fifo_drop_count);
    $display("Test passed");
    $finish;
end

endmodule

/* verification/frame_input.txt */
# name kind length payload_bytes fcs_on_wire (hex, fcs 00000000 means computed)
# kind overflow gives one seed byte, payload counts up from it
one_byte good 1 61 e8b7be43
abc good 3 61 62 63 352441c2
digits good 9 31 32 33 34 35 36 37 38 39 cbf43926
fox good 43 54 68 65 20 71 75 69 63 6b 20 62 72 6f 77 6e 20 66 6f 78 20 6a 75 6d 70 73 20 6f 76 65 72 20 74 68 65 20 6c 61 7a 79 20 64 6f 67 414fa339
bad_fcs badfcs 9 31 32 33 34 35 36 37 38 39 12345678
rx_error rxerr 3 61 62 63 352441c2
count64 good 64 00 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10 11 12 13 14 15 16 17 18 19 1a 1b 1c 1d 1e 1f 20 21 22 23 24 25 26 27 28 29 2a 2b 2c 2d 2e 2f 30 31 32 33 34 35 36 37 38 39 3a 3b 3c 3d 3e 3f 00000000
burst_a overflow 1000 10 00000000
burst_big overflow 2100 20 00000000
burst_b overflow 1000 30 00000000
after_burst good 3 61 62 63 352441c2

/* vlog.f */
design/eth_pkg.sv
design/gmii_rx_stage.sv
design/frame_fifo.sv
design/gmii_tx_stage.sv
design/fpga_core.sv
verification/fpga_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the loopback testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module fpga_core_tb -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vfpga_core_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
fi

if grep -qx "Test passed" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
